// ==== Makefile ====
VERILATOR  := verilator
TOP        := la_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing
SIM_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+logic
logic/la_pkg.sv
logic/la_config_regs.sv
logic/la_trigger_capture.sv
logic/la_sync_fifo.sv
logic/la_burst_writer.sv
logic/la_burst_reader.sv
logic/la_sample_mem.sv
logic/la_top.sv
tests/la_asserts.sv
tests/la_tb.sv

// ==== logic/la_burst_reader.sv ====
`include "la_macros.svh"

module la_burst_reader (
    input  logic                              clk_ip,
    input  logic                              rst_n,
    input  logic                              read_start,
    input  la_pkg::mem_addr_t                 words_stored,
    input  la_pkg::word_t                     mem_rdata,
    input  logic [$clog2(`LA_FIFO_DEPTH):0]   out_count,
    output logic                              mem_re,
    output la_pkg::mem_addr_t                 mem_raddr,
    output logic                              out_push,
    output la_pkg::rd_beat_t                  out_beat,
    output logic                              read_busy
);
    import la_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT,
        R_READ
    } rd_state_e;

    rd_state_e  state;
    mem_addr_t  rd_ptr;
    mem_addr_t  remaining;
    logic [4:0] burst_next;
    logic [4:0] burst_len;
    logic [4:0] beat_cnt;
    logic       room;
    logic       last_q;

    assign remaining  = words_stored - rd_ptr;
    assign burst_next = (remaining > `LA_MAX_BURST) ? 5'(`LA_MAX_BURST) : remaining[4:0];

    // one more slot for the word still in flight from the last burst
    assign room = (out_count + burst_next + 1) <= `LA_FIFO_DEPTH;

    assign mem_re        = (state == R_READ);
    assign mem_raddr     = rd_ptr;
    assign out_beat.data = mem_rdata;
    assign out_beat.last = last_q;

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state     <= R_IDLE;
            rd_ptr    <= '0;
            burst_len <= '0;
            beat_cnt  <= '0;
            read_busy <= 1'b0;
            out_push  <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            // memory data lands one cycle after the read
            out_push <= mem_re;
            last_q   <= mem_re && (rd_ptr == words_stored - 1'b1);
            case (state)
                R_IDLE: begin
                    if (read_start && (words_stored != '0)) begin
                        rd_ptr    <= '0;
                        read_busy <= 1'b1;
                        state     <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (remaining == '0) begin
                        read_busy <= 1'b0;
                        state     <= R_IDLE;
                    end else if (room) begin
                        burst_len <= burst_next;
                        beat_cnt  <= '0;
                        state     <= R_READ;
                    end
                end
                R_READ: begin
                    rd_ptr   <= rd_ptr + 1'b1;
                    beat_cnt <= beat_cnt + 5'd1;
                    if (beat_cnt == burst_len - 5'd1) begin
                        state <= R_WAIT;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/la_burst_writer.sv ====
`include "la_macros.svh"

module la_burst_writer (
    input  logic                              clk_ip,
    input  logic                              rst_n,
    input  logic                              arm,
    input  logic                              fifo_empty,
    input  logic [$clog2(`LA_FIFO_DEPTH):0]   fifo_count,
    input  la_pkg::word_t                     fifo_data,
    output logic                              fifo_pop,
    output logic                              mem_we,
    output la_pkg::mem_addr_t                 mem_waddr,
    output la_pkg::word_t                     mem_wdata,
    output la_pkg::mem_addr_t                 words_stored
);
    import la_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_SETUP,
        W_DATA
    } wr_state_e;

    wr_state_e state;
    mem_addr_t wr_ptr;
    logic [4:0] burst_len;
    logic [4:0] beat_cnt;
    logic       last_beat;

    assign last_beat    = (beat_cnt == burst_len - 5'd1);
    assign fifo_pop     = (state == W_DATA);
    assign mem_we       = (state == W_DATA);
    assign mem_waddr    = wr_ptr;
    assign mem_wdata    = fifo_data;
    assign words_stored = wr_ptr;

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state     <= W_IDLE;
            wr_ptr    <= '0;
            burst_len <= '0;
            beat_cnt  <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (!fifo_empty) begin
                        state <= W_SETUP;
                    end
                end
                W_SETUP: begin
                    // only the writer pops, so these words stay available
                    burst_len <= (fifo_count > `LA_MAX_BURST) ?
                                 5'(`LA_MAX_BURST) : fifo_count[4:0];
                    beat_cnt  <= '0;
                    state     <= W_DATA;
                end
                W_DATA: begin
                    wr_ptr   <= wr_ptr + 1'b1;
                    beat_cnt <= beat_cnt + 5'd1;
                    if (last_beat) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
            if (arm) begin
                wr_ptr <= '0;
            end
        end
    end

endmodule

// ==== logic/la_config_regs.sv ====
`include "la_macros.svh"

module la_config_regs (
    input  logic                  clk_ip,
    input  logic                  rst_n,
    input  logic [`LA_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    input  logic                  capturing,
    input  logic                  overflow,
    input  logic                  read_busy,
    input  la_pkg::mem_addr_t     words_stored,
    output logic [31:0]           prdata,
    output logic                  arm,
    output logic                  read_start,
    output la_pkg::trig_mode_e    trig_mode,
    output la_pkg::sample_t       trig_pattern,
    output la_pkg::sample_t       trig_mask,
    output la_pkg::mem_addr_t     capture_words
);
    import la_pkg::*;

    logic wr_en;
    logic capture_done;

    assign wr_en = psel && penable && pwrite;

    // depth 0 never counts as done
    assign capture_done = (capture_words != '0) && (words_stored == capture_words);

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            arm           <= 1'b0;
            read_start    <= 1'b0;
            trig_mode     <= TRIG_IMMEDIATE;
            trig_pattern  <= '0;
            trig_mask     <= '0;
            capture_words <= '0;
        end else begin
            // command bits are pulses, nothing is stored
            arm        <= wr_en && (paddr == `LA_REG_CTRL) && pwdata[0];
            read_start <= wr_en && (paddr == `LA_REG_CTRL) && pwdata[1];
            if (wr_en && (paddr == `LA_REG_TRIG)) begin
                trig_mode    <= trig_mode_e'(pwdata[1:0]);
                trig_pattern <= pwdata[8 +: `LA_SAMPLE_W];
            end
            if (wr_en && (paddr == `LA_REG_MASK)) begin
                trig_mask <= pwdata[`LA_SAMPLE_W-1:0];
            end
            if (wr_en && (paddr == `LA_REG_DEPTH)) begin
                capture_words <= pwdata[`LA_MEM_AW:0];
            end
        end
    end

    always_comb begin
        case (paddr)
            `LA_REG_TRIG:   prdata = {18'd0, trig_pattern, 6'd0, trig_mode};
            `LA_REG_MASK:   prdata = {26'd0, trig_mask};
            `LA_REG_DEPTH:  prdata = {{(31 - `LA_MEM_AW){1'b0}}, capture_words};
            `LA_REG_STATUS: prdata = {5'd0, words_stored, 12'd0,
                                      overflow, read_busy, capturing, capture_done};
            default:        prdata = 32'd0;
        endcase
    end

endmodule

// ==== logic/la_macros.svh ====
`ifndef LA_MACROS_SVH
`define LA_MACROS_SVH

`define LA_SAMPLE_W    6
`define LA_LANE_W      8
`define LA_LANES       8
`define LA_WORD_W      64
`define LA_MEM_AW      10
`define LA_MAX_BURST   16
`define LA_FIFO_DEPTH  32

`define LA_APB_AW      8
`define LA_REG_CTRL    8'h00
`define LA_REG_TRIG    8'h04
`define LA_REG_MASK    8'h08
`define LA_REG_DEPTH   8'h0C
`define LA_REG_STATUS  8'h10

`endif

// ==== logic/la_pkg.sv ====
`include "la_macros.svh"

package la_pkg;

    typedef logic [`LA_WORD_W-1:0] word_t;

    // address, or a word count up to the full depth
    typedef logic [`LA_MEM_AW:0] mem_addr_t;

    typedef logic [`LA_SAMPLE_W-1:0] sample_t;

    typedef enum logic [1:0] {
        TRIG_IMMEDIATE = 2'd0,
        TRIG_MATCH     = 2'd1,
        TRIG_RISE      = 2'd2,
        TRIG_FALL      = 2'd3
    } trig_mode_e;

    typedef struct packed {
        word_t data;
        logic  last;
    } rd_beat_t;

endpackage

// ==== logic/la_sample_mem.sv ====
`include "la_macros.svh"

module la_sample_mem (
    input  logic                  clk_ip,
    input  logic                  we,
    input  logic [`LA_MEM_AW-1:0] waddr,
    input  la_pkg::word_t         wdata,
    input  logic                  re,
    input  logic [`LA_MEM_AW-1:0] raddr,
    output la_pkg::word_t         rdata
);
    import la_pkg::*;

    word_t mem [1 << `LA_MEM_AW];

    always_ff @(posedge clk_ip) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // registered read port
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== logic/la_sync_fifo.sv ====
module la_sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 32
) (
    input  logic                   clk_ip,
    input  logic                   rst_n,
    input  logic                   push,
    input  payload_t               push_data,
    input  logic                   pop,
    output payload_t               pop_data,
    output logic                   empty,
    output logic                   full,
    output logic [$clog2(DEPTH):0] count
);
    localparam int AW = $clog2(DEPTH);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            do_push;
    logic            do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == DEPTH[AW:0]);

    // fall-through head of the buffer
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk_ip) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

endmodule

// ==== logic/la_top.sv ====
`include "la_macros.svh"

module la_top (
    input  logic                  clk_ip,
    input  logic                  rst_n,
    input  la_pkg::sample_t       din,
    input  logic [`LA_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    input  logic                  rd_ready,
    output logic [31:0]           prdata,
    output la_pkg::word_t         rd_data,
    output logic                  rd_last,
    output logic                  rd_valid
);
    import la_pkg::*;

    logic       arm;
    logic       read_start;
    trig_mode_e trig_mode;
    sample_t    trig_pattern;
    sample_t    trig_mask;
    mem_addr_t  capture_words;
    logic       capturing;
    logic       overflow;
    logic       read_busy;
    mem_addr_t  words_stored;

    logic       cap_push;
    word_t      cap_word;
    logic       cap_pop;
    word_t      cap_head;
    logic       cap_empty;
    logic       cap_full;
    logic [$clog2(`LA_FIFO_DEPTH):0] cap_count;

    logic       mem_we;
    mem_addr_t  mem_waddr;
    word_t      mem_wdata;
    logic       mem_re;
    mem_addr_t  mem_raddr;
    word_t      mem_rdata;

    logic       out_push;
    rd_beat_t   out_beat;
    logic       out_pop;
    rd_beat_t   out_head;
    logic       out_empty;
    logic [$clog2(`LA_FIFO_DEPTH):0] out_count;

    assign rd_valid = !out_empty;
    assign out_pop  = rd_valid && rd_ready;
    assign rd_data  = out_head.data;
    assign rd_last  = out_head.last;

    la_config_regs u_cfg (
        .clk_ip(clk_ip), .rst_n(rst_n), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .capturing(capturing), .overflow(overflow), .read_busy(read_busy),
        .words_stored(words_stored), .prdata(prdata), .arm(arm),
        .read_start(read_start), .trig_mode(trig_mode), .trig_pattern(trig_pattern),
        .trig_mask(trig_mask), .capture_words(capture_words)
    );

    la_trigger_capture u_cap (
        .clk_ip(clk_ip), .rst_n(rst_n), .din(din), .arm(arm),
        .trig_mode(trig_mode), .trig_pattern(trig_pattern), .trig_mask(trig_mask),
        .capture_words(capture_words), .fifo_full(cap_full), .push(cap_push),
        .push_word(cap_word), .capturing(capturing), .overflow(overflow)
    );

    la_sync_fifo #(.payload_t(word_t), .DEPTH(`LA_FIFO_DEPTH)) u_cap_fifo (
        .clk_ip(clk_ip), .rst_n(rst_n), .push(cap_push), .push_data(cap_word),
        .pop(cap_pop), .pop_data(cap_head), .empty(cap_empty), .full(cap_full),
        .count(cap_count)
    );

    la_burst_writer u_writer (
        .clk_ip(clk_ip), .rst_n(rst_n), .arm(arm), .fifo_empty(cap_empty),
        .fifo_count(cap_count), .fifo_data(cap_head), .fifo_pop(cap_pop),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .words_stored(words_stored)
    );

    la_sample_mem u_mem (
        .clk_ip(clk_ip), .we(mem_we), .waddr(mem_waddr[`LA_MEM_AW-1:0]),
        .wdata(mem_wdata), .re(mem_re), .raddr(mem_raddr[`LA_MEM_AW-1:0]),
        .rdata(mem_rdata)
    );

    la_burst_reader u_reader (
        .clk_ip(clk_ip), .rst_n(rst_n), .read_start(read_start),
        .words_stored(words_stored), .mem_rdata(mem_rdata), .out_count(out_count),
        .mem_re(mem_re), .mem_raddr(mem_raddr), .out_push(out_push),
        .out_beat(out_beat), .read_busy(read_busy)
    );

    la_sync_fifo #(.payload_t(rd_beat_t), .DEPTH(`LA_FIFO_DEPTH)) u_out_fifo (
        .clk_ip(clk_ip), .rst_n(rst_n), .push(out_push), .push_data(out_beat),
        .pop(out_pop), .pop_data(out_head), .empty(out_empty), .full(),
        .count(out_count)
    );

endmodule

// ==== logic/la_trigger_capture.sv ====
`include "la_macros.svh"

module la_trigger_capture (
    input  logic               clk_ip,
    input  logic               rst_n,
    input  la_pkg::sample_t    din,
    input  logic               arm,
    input  la_pkg::trig_mode_e trig_mode,
    input  la_pkg::sample_t    trig_pattern,
    input  la_pkg::sample_t    trig_mask,
    input  la_pkg::mem_addr_t  capture_words,
    input  logic               fifo_full,
    output logic               push,
    output la_pkg::word_t      push_word,
    output logic               capturing,
    output logic               overflow
);
    import la_pkg::*;

    sample_t   prev_din;
    logic      active;
    logic      trig_hit;
    logic      take;
    logic      word_ready;
    logic [2:0] lane_cnt;
    mem_addr_t word_cnt;
    word_t     word_q;

    always_comb begin
        case (trig_mode)
            TRIG_MATCH: trig_hit = ((din ^ trig_pattern) & trig_mask) == '0;
            TRIG_RISE:  trig_hit = |(~prev_din & din & trig_mask);
            TRIG_FALL:  trig_hit = |(prev_din & ~din & trig_mask);
            default:    trig_hit = 1'b1;
        endcase
    end

    // sample goes into the current lane
    assign take = capturing && (active || trig_hit);

    // a full FIFO drops the word instead of taking it
    assign push      = word_ready && !fifo_full;
    assign push_word = word_q;

    always_ff @(posedge clk_ip) begin
        prev_din <= din;
        if (take) begin
            word_q[lane_cnt*`LA_LANE_W +: `LA_LANE_W] <=
                {{(`LA_LANE_W - `LA_SAMPLE_W){1'b0}}, din};
        end
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            capturing  <= 1'b0;
            active     <= 1'b0;
            overflow   <= 1'b0;
            word_ready <= 1'b0;
            lane_cnt   <= '0;
            word_cnt   <= '0;
        end else if (arm) begin
            capturing  <= 1'b1;
            active     <= 1'b0;
            overflow   <= 1'b0;
            word_ready <= 1'b0;
            lane_cnt   <= '0;
            word_cnt   <= '0;
        end else begin
            word_ready <= take && (lane_cnt == 3'd7);
            if (word_ready && fifo_full) begin
                overflow <= 1'b1;
            end
            if (take) begin
                active   <= 1'b1;
                lane_cnt <= lane_cnt + 3'd1;
                if (lane_cnt == 3'd7) begin
                    word_cnt <= word_cnt + 1'b1;
                    // last word completed
                    if (word_cnt + 1'b1 == capture_words) begin
                        capturing <= 1'b0;
                        active    <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== tests/la_asserts.sv ====
`include "la_macros.svh"

module la_asserts (
    input  logic                            clk_ip,
    input  logic                            rst_n,
    input  logic                            overflow,
    input  logic                            out_push,
    input  logic [$clog2(`LA_FIFO_DEPTH):0] out_count,
    input  logic                            mem_we,
    input  logic                            rd_valid,
    input  logic                            rd_ready,
    input  la_pkg::word_t                   rd_data
);
    int fail_count = 0;
    int we_run;

    // writes already done in the current burst
    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            we_run <= 0;
        end else if (mem_we) begin
            we_run <= we_run + 1;
        end else begin
            we_run <= 0;
        end
    end

    // a finished word met a full capture FIFO
    cap_no_overrun: assert property (@(posedge clk_ip) disable iff (!rst_n)
        !overflow)
    else begin
        fail_count++;
        $error("push into a full capture FIFO");
    end

    out_no_overrun: assert property (@(posedge clk_ip) disable iff (!rst_n)
        !(out_push && (out_count == `LA_FIFO_DEPTH)))
    else begin
        fail_count++;
        $error("push into a full output FIFO");
    end

    rd_hold: assert property (@(posedge clk_ip) disable iff (!rst_n)
        (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)))
    else begin
        fail_count++;
        $error("readback beat changed or vanished while stalled");
    end

    burst_limit: assert property (@(posedge clk_ip) disable iff (!rst_n)
        mem_we |-> (we_run < `LA_MAX_BURST))
    else begin
        fail_count++;
        $error("writer burst longer than the maximum");
    end

endmodule

bind la_top la_asserts u_asserts (
    .clk_ip(clk_ip), .rst_n(rst_n), .overflow(overflow),
    .out_push(out_push), .out_count(out_count), .mem_we(mem_we),
    .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_data(rd_data)
);

// ==== tests/la_tb.sv ====
`include "la_macros.svh"

module la_tb;
    import la_pkg::*;

    localparam int TOTAL_SAMPLES = (20 + 10 + 10 + 50 + 24) * `LA_LANES;
    localparam int INSERT_AT     = 12;

    logic                  clk_ip = 1'b0;
    logic                  rst_n;
    sample_t               din;
    logic [`LA_APB_AW-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic                  rd_ready;
    logic [31:0]           prdata;
    word_t                 rd_data;
    logic                  rd_last;
    logic                  rd_valid;

    sample_t     hist[$];
    word_t       exp_q[$];
    logic        recording  = 1'b0;
    logic        count_mode = 1'b0;
    logic        bp_on      = 1'b0;
    logic        have_prev  = 1'b0;
    sample_t     prev_lane;
    logic [31:0] lcg_din    = 32'd1;
    logic [31:0] lcg_rdy    = 32'd1;
    int          beats_seen  = 0;
    int          beats_total = 0;
    int          checks      = 0;
    int          errors      = 0;

    la_top la_top_inst (
        .clk_ip(clk_ip), .rst_n(rst_n), .din(din), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .rd_ready(rd_ready),
        .prdata(prdata), .rd_data(rd_data), .rd_last(rd_last), .rd_valid(rd_valid)
    );

    always #5 clk_ip = ~clk_ip;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // bend a sample so that it cannot fire the trigger
    function automatic sample_t avoid_trigger(input trig_mode_e mode, input sample_t pat,
                                              input sample_t mask, input sample_t s);
        sample_t r;
        r = s;
        case (mode)
            TRIG_MATCH: begin
                if ((r & mask) == (pat & mask)) begin
                    r = r ^ (mask & (~mask + 6'd1));
                end
            end
            TRIG_RISE: r = r & ~mask;
            TRIG_FALL: r = r | mask;
            default:   r = s;
        endcase
        return r;
    endfunction

    // first recorded sample on which the trigger holds
    function automatic int find_trigger(input trig_mode_e mode, input sample_t pat,
                                        input sample_t mask);
        sample_t cur;
        sample_t prev;
        logic    hit;
        for (int i = 1; i < hist.size(); i++) begin
            cur  = hist[i];
            prev = hist[i-1];
            case (mode)
                TRIG_MATCH: hit = (cur & mask) == (pat & mask);
                TRIG_RISE:  hit = ((cur & ~prev) & mask) != '0;
                TRIG_FALL:  hit = ((prev & ~cur) & mask) != '0;
                default:    hit = 1'b1;
            endcase
            if (hit) begin
                return i;
            end
        end
        return -1;
    endfunction

    // word k after the trigger, lane 0 in the low byte
    function automatic word_t ref_word(input int trig, input int k);
        word_t w;
        w = '0;
        for (int j = 0; j < `LA_LANES; j++) begin
            w[j*`LA_LANE_W +: `LA_LANE_W] = {2'b00, hist[trig + k*`LA_LANES + j]};
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic write_reg(input logic [`LA_APB_AW-1:0] addr, input logic [31:0] data);
        @(negedge clk_ip);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_ip);
        penable = 1'b1;
        @(negedge clk_ip);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [`LA_APB_AW-1:0] addr, output logic [31:0] data);
        @(negedge clk_ip);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_ip);
        penable = 1'b1;
        @(negedge clk_ip);
        data    = prdata;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_status(input int bit_idx, input logic value);
        logic [31:0] st;
        read_reg(`LA_REG_STATUS, st);
        while (st[bit_idx] !== value) begin
            read_reg(`LA_REG_STATUS, st);
        end
    endtask

    task automatic drive_samples(input trig_mode_e mode, input sample_t pat,
                                 input sample_t mask, input int n);
        sample_t s;
        for (int i = 0; i < n; i++) begin
            @(negedge clk_ip);
            lcg_din = lcg_next(lcg_din);
            s = lcg_din[21:16];
            if (i < INSERT_AT) begin
                s = avoid_trigger(mode, pat, mask, s);
            end else if (i == INSERT_AT) begin
                case (mode)
                    TRIG_MATCH: s = pat;
                    TRIG_RISE:  s = s | mask;
                    TRIG_FALL:  s = s & ~mask;
                    default:    s = s;
                endcase
            end
            din = s;
        end
    endtask

    task automatic drive_count(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk_ip);
            din = din + 6'd1;
        end
    endtask

    task automatic capture_triggered(input trig_mode_e mode, input sample_t pat,
                                     input sample_t mask, input int depth);
        logic [31:0] st;
        int          trig;
        write_reg(`LA_REG_TRIG, {18'd0, pat, 6'd0, mode});
        write_reg(`LA_REG_MASK, {26'd0, mask});
        write_reg(`LA_REG_DEPTH, 32'(depth));
        @(negedge clk_ip);
        din = avoid_trigger(mode, pat, mask, din);
        hist.delete();
        recording = 1'b1;
        write_reg(`LA_REG_CTRL, 32'h1);
        drive_samples(mode, pat, mask, INSERT_AT + depth * `LA_LANES + 4);
        wait_status(0, 1'b1);
        recording = 1'b0;
        read_reg(`LA_REG_STATUS, st);
        check_value("words_stored", st[26:16], depth);
        check_value("overflow", st[3], 0);
        trig = find_trigger(mode, pat, mask);
        assert (trig >= 0) else begin
            errors++;
            $display("trigger condition never seen in the recorded input");
        end
        exp_q.delete();
        for (int k = 0; k < depth; k++) begin
            exp_q.push_back(ref_word(trig, k));
        end
        count_mode = 1'b0;
    endtask

    task automatic read_back(input int depth, input logic stalls);
        beats_seen  = 0;
        beats_total = depth;
        bp_on       = stalls;
        write_reg(`LA_REG_CTRL, 32'h2);
        wait (beats_seen == depth);
        wait_status(2, 1'b0);
        bp_on = 1'b0;
        @(negedge clk_ip);
        check_value("rd_valid", rd_valid, 0);
    endtask

    always @(posedge clk_ip) begin
        if (recording) begin
            hist.push_back(din);
        end
    end

    always @(negedge clk_ip) begin
        if (bp_on) begin
            lcg_rdy  = lcg_next(lcg_rdy);
            rd_ready = lcg_rdy[16];
        end else begin
            rd_ready = 1'b1;
        end
    end

    // every transferred beat against the expected stream
    always @(posedge clk_ip) begin
        word_t   exp_word;
        sample_t lane;
        if (rst_n && rd_valid && rd_ready) begin
            if (count_mode) begin
                for (int j = 0; j < `LA_LANES; j++) begin
                    check_value("rd_data lane upper bits", rd_data[j*`LA_LANE_W + 6 +: 2], 0);
                    lane = rd_data[j*`LA_LANE_W +: `LA_SAMPLE_W];
                    if (have_prev) begin
                        check_value("rd_data lane", lane, sample_t'(prev_lane + 6'd1));
                    end
                    prev_lane = lane;
                    have_prev = 1'b1;
                end
            end else begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("beat %0d arrived with no word left to expect", beats_seen);
                end
                if (exp_q.size() != 0) begin
                    exp_word = exp_q.pop_front();
                    check_value("rd_data", rd_data, exp_word);
                end
            end
            check_value("rd_last", rd_last, beats_seen == beats_total - 1);
            beats_seen++;
        end
    end

    initial begin
        repeat (40 * TOTAL_SAMPLES) @(posedge clk_ip);
        $display("timeout: run not finished after %0d clock periods", 40 * TOTAL_SAMPLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        rst_n    = 1'b0;
        din      = '0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        rd_ready = 1'b1;
        repeat (10) @(posedge clk_ip);
        @(negedge clk_ip);
        rst_n = 1'b1;

        check_value("rd_valid", rd_valid, 0);
        read_reg(`LA_REG_STATUS, rdata);
        check_value("status", rdata, 0);

        write_reg(`LA_REG_TRIG, 32'h0000_2A01);
        write_reg(`LA_REG_MASK, 32'h0000_003F);
        write_reg(`LA_REG_DEPTH, 32'h0000_0014);
        read_reg(`LA_REG_TRIG, rdata);
        check_value("trig", rdata, 32'h2A01);
        read_reg(`LA_REG_MASK, rdata);
        check_value("mask", rdata, 32'h3F);
        read_reg(`LA_REG_DEPTH, rdata);
        check_value("depth", rdata, 32'h14);
        // both command bits set, nothing may be held
        write_reg(`LA_REG_CTRL, 32'h3);
        read_reg(`LA_REG_CTRL, rdata);
        check_value("ctrl", rdata, 0);

        capture_triggered(TRIG_MATCH, 6'h2A, 6'h3F, 20);
        read_back(20, 1'b0);

        // single masked bit for the edge types
        capture_triggered(TRIG_RISE, 6'h00, 6'h04, 10);
        read_back(10, 1'b0);
        capture_triggered(TRIG_FALL, 6'h00, 6'h10, 10);
        read_back(10, 1'b0);

        capture_triggered(TRIG_MATCH, 6'h15, 6'h3F, 50);
        read_back(50, 1'b1);

        // counting input, capture starts at once
        write_reg(`LA_REG_TRIG, 32'h0);
        write_reg(`LA_REG_DEPTH, 32'd24);
        count_mode = 1'b1;
        have_prev  = 1'b0;
        fork
            drive_count(24 * `LA_LANES + 40);
            write_reg(`LA_REG_CTRL, 32'h1);
        join
        wait_status(0, 1'b1);
        read_reg(`LA_REG_STATUS, rdata);
        check_value("overflow", rdata[3], 0);
        read_back(24, 1'b0);

        $display("checks: %0d, check errors: %0d, assertion errors: %0d",
                 checks, errors, la_top_inst.u_asserts.fail_count);
        if (errors == 0 && la_top_inst.u_asserts.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
